// ==== source/wbuf_config.svh ====
/* weight buffer sizing; WB_BANK_AW must cover WB_K*WB_K taps
   WB_TOTAL is derived, do not override it on its own */
`ifndef WBUF_CONFIG_SVH
`define WBUF_CONFIG_SVH

`define WB_DW       16  // coefficient width
`define WB_TN       2   // output channels per tile
`define WB_TM       2   // input channels per tile
`define WB_K        3   // kernel side

// bank depth, 9 taps fit in 16 words
`define WB_BANK_AW  4

// coefficients in one full load
`define WB_TOTAL    (`WB_TN * `WB_TM * `WB_K * `WB_K)

`endif

// ==== source/wbuf_pkg.sv ====
/* write command and weight vector types shared by the weight buffer
   bank order is output channel major, input channel minor */
`include "wbuf_config.svh"

package wbuf_pkg;

    // registered write into the bank array
    typedef struct packed {
        logic [`WB_DW-1:0]             data;
        logic [`WB_BANK_AW-1:0]        tap;
        logic [`WB_TN*`WB_TM-1:0]      bank_sel;  // one-hot, zero when idle
    } wb_write_t;

    // one tap of every kernel, coef[oc][ic]
    typedef struct packed {
        logic [`WB_TN-1:0][`WB_TM-1:0][`WB_DW-1:0] coef;
    } wb_weights_t;

endpackage

// ==== source/weight_write_router.sv ====
/* stream must arrive as output channel, input channel, tap
   load_start must not coincide with wr_ena; counters wrap after a full load */
`timescale 1ns/10ps
`include "wbuf_config.svh"

module weight_write_router
    import wbuf_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_ena,
    input  logic [`WB_DW-1:0] wr_data,
    input  logic              load_start,
    output wb_write_t         wr_cmd
);
    localparam int taps   = `WB_K * `WB_K;
    localparam int nb     = `WB_TN * `WB_TM;
    localparam int icw    = (`WB_TM > 1) ? $clog2(`WB_TM) : 1;
    localparam int ocw    = (`WB_TN > 1) ? $clog2(`WB_TN) : 1;
    localparam int bw     = (nb > 1) ? $clog2(nb) : 1;

    localparam logic [`WB_BANK_AW-1:0] tap_last = `WB_BANK_AW'(taps - 1);
    localparam logic [icw-1:0]         ic_last  = icw'(`WB_TM - 1);
    localparam logic [ocw-1:0]         oc_last  = ocw'(`WB_TN - 1);

    logic [`WB_BANK_AW-1:0] tap_cnt;
    logic [icw-1:0]         ic_cnt;
    logic [ocw-1:0]         oc_cnt;
    logic [bw-1:0]          bank_idx;
    logic [nb-1:0]          sel_next;

    logic [`WB_DW-1:0]      cmd_data;
    logic [`WB_BANK_AW-1:0] cmd_tap;
    logic [nb-1:0]          cmd_sel;

    // tap -> input channel -> output channel carry chain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_cnt <= '0;
            ic_cnt  <= '0;
            oc_cnt  <= '0;
        end else if (load_start) begin
            tap_cnt <= '0;
            ic_cnt  <= '0;
            oc_cnt  <= '0;
        end else if (wr_ena) begin
            if (tap_cnt == tap_last) begin
                tap_cnt <= '0;
                if (ic_cnt == ic_last) begin
                    ic_cnt <= '0;
                    oc_cnt <= (oc_cnt == oc_last) ? '0 : oc_cnt + 1'b1;
                end else begin
                    ic_cnt <= ic_cnt + 1'b1;
                end
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    assign bank_idx = bw'(oc_cnt * `WB_TM) + bw'(ic_cnt);
    assign sel_next = wr_ena ? (nb'(1) << bank_idx) : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_sel <= '0;
        end else begin
            cmd_sel <= sel_next;
        end
    end

    always_ff @(posedge clk) begin
        cmd_data <= wr_data;
        cmd_tap  <= tap_cnt;  // position of this word within its kernel
    end

    assign wr_cmd = '{data: cmd_data, tap: cmd_tap, bank_sel: cmd_sel};

    // a restart during a write would drop or misplace that word
    a_load_vs_write: assert property (@(posedge clk) disable iff (rst)
        !(load_start && wr_ena));

endmodule

// ==== source/weight_bank.sv ====
/* one K*K kernel, write on own select bit, read data one clock after rd_tap
   no read/write collision handling, reads must not overlap writes */
`timescale 1ns/10ps
`include "wbuf_config.svh"

module weight_bank
    import wbuf_pkg::*;
#(
    parameter int bank_index = 0
)(
    input  logic                   clk,
    input  wb_write_t              wr_cmd,
    input  logic [`WB_BANK_AW-1:0] rd_tap,
    output logic [`WB_DW-1:0]      rd_data
);
    localparam int taps = `WB_K * `WB_K;

    logic [`WB_DW-1:0] mem [0:taps-1];

    always_ff @(posedge clk) begin
        if (wr_cmd.bank_sel[bank_index]) begin
            mem[wr_cmd.tap] <= wr_cmd.data;
        end
        rd_data <= mem[rd_tap];  // registered read
    end

    // router tap counter must carry at K*K
    a_tap_range: assert property (@(posedge clk)
        wr_cmd.bank_sel[bank_index] |-> (int'(wr_cmd.tap) < taps));

endmodule

// ==== source/weight_tap_sequencer.sv ====
/* rd_start gives K*K valid cycles starting three clocks later
   rd_start during a running sweep is illegal */
`timescale 1ns/10ps
`include "wbuf_config.svh"

module weight_tap_sequencer
    import wbuf_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  rd_start,
    output logic [`WB_BANK_AW-1:0]                rd_tap,
    input  logic [`WB_TN*`WB_TM-1:0][`WB_DW-1:0]  bank_data,
    output wb_weights_t                           weights,
    output logic                                  rd_valid,
    output logic                                  rd_last
);
    localparam int taps = `WB_K * `WB_K;
    localparam logic [`WB_BANK_AW-1:0] tap_last = `WB_BANK_AW'(taps - 1);

    logic                   busy;
    logic [`WB_BANK_AW-1:0] tap_cnt;
    logic                   a_valid;  // address register stage
    logic                   a_last;
    logic                   b_valid;  // bank read stage
    logic                   b_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            tap_cnt <= '0;
        end else if (rd_start) begin
            busy    <= 1'b1;
            tap_cnt <= '0;
        end else if (busy) begin
            if (tap_cnt == tap_last) begin
                busy <= 1'b0;
            end
            tap_cnt <= tap_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            rd_tap <= tap_cnt;
        end
    end

    // valid/last follow the tap through the bank and output registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_valid  <= 1'b0;
            a_last   <= 1'b0;
            b_valid  <= 1'b0;
            b_last   <= 1'b0;
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            a_valid  <= busy;
            a_last   <= busy && (tap_cnt == tap_last);
            b_valid  <= a_valid;
            b_last   <= a_last;
            rd_valid <= b_valid;
            rd_last  <= b_last;
        end
    end

    always_ff @(posedge clk) begin
        if (b_valid) begin
            weights <= wb_weights_t'(bank_data);  // hold last tap when idle
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        busy |-> !rd_start);

endmodule

// ==== source/weight_buffer.sv ====
/* weight buffer tile, sequential coefficient load and shared tap sweep
   a sweep must start at least one cycle after the last write */
`timescale 1ns/10ps
`include "wbuf_config.svh"

module weight_buffer
    import wbuf_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_ena,
    input  logic [`WB_DW-1:0] wr_data,
    input  logic              load_start,
    input  logic              rd_start,
    output wb_weights_t       weights,
    output logic              rd_valid,
    output logic              rd_last
);
    wb_write_t                                 wr_cmd;
    logic [`WB_BANK_AW-1:0]                    rd_tap;
    logic [`WB_TN*`WB_TM-1:0][`WB_DW-1:0]      bank_data;

    weight_write_router i_router (
        .clk        (clk),
        .rst        (rst),
        .wr_ena     (wr_ena),
        .wr_data    (wr_data),
        .load_start (load_start),
        .wr_cmd     (wr_cmd)
    );

    // bank b holds kernel (b / WB_TM, b % WB_TM)
    for (genvar b = 0; b < `WB_TN * `WB_TM; b++) begin : g_bank
        weight_bank #(
            .bank_index (b)
        ) i_bank (
            .clk     (clk),
            .wr_cmd  (wr_cmd),
            .rd_tap  (rd_tap),
            .rd_data (bank_data[b])
        );
    end

    weight_tap_sequencer i_seq (
        .clk       (clk),
        .rst       (rst),
        .rd_start  (rd_start),
        .rd_tap    (rd_tap),
        .bank_data (bank_data),
        .weights   (weights),
        .rd_valid  (rd_valid),
        .rd_last   (rd_last)
    );

endmodule

// ==== bench/tb_weight_buffer.sv ====
/* testbench for the weight buffer, first load read from bench/weight_testdata.hex
   expects to run from the project root; inputs change 2 ns after the rising edge */
`timescale 1ns/10ps
`include "wbuf_config.svh"

module tb_weight_buffer
    import wbuf_pkg::*;
();
    localparam int taps     = `WB_K * `WB_K;
    localparam int total    = `WB_TOTAL;
    localparam int vw       = $bits(wb_weights_t);
    localparam int timeout  = 50;  // cycles to wait for rd_valid

    logic              clk;
    logic              rst;
    logic              wr_ena;
    logic [`WB_DW-1:0] wr_data;
    logic              load_start;
    logic              rd_start;
    wb_weights_t       weights;
    logic              rd_valid;
    logic              rd_last;

    logic [`WB_DW-1:0] file_words [0:total-1];
    logic [`WB_DW-1:0] model [0:total-1];  // stream position n -> coefficient
    wb_weights_t       sweep_vec [0:15];
    wb_weights_t       first_vec [0:taps-1];
    int                sweep_lat;
    int                sweep_cnt;
    logic [15:0]       last_mask;
    bit                sweep_timeout;
    int                errors;
    int                failed_tests;
    int                tests_run;
    int                test_err_start;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    weight_buffer i_dut (
        .clk        (clk),
        .rst        (rst),
        .wr_ena     (wr_ena),
        .wr_data    (wr_data),
        .load_start (load_start),
        .rd_start   (rd_start),
        .weights    (weights),
        .rd_valid   (rd_valid),
        .rd_last    (rd_last)
    );

    task check_value(input string name, input logic [vw-1:0] expected,
                     input logic [vw-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task write_word(input logic [`WB_DW-1:0] d);
        @(posedge clk);
        #2;
        wr_ena     = 1'b1;
        wr_data    = d;
        load_start = 1'b0;
        rd_start   = 1'b0;
    endtask

    task idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            wr_ena     = 1'b0;
            load_start = 1'b0;
            rd_start   = 1'b0;
        end
    endtask

    task pulse_load_start();
        @(posedge clk);
        #2;
        wr_ena     = 1'b0;
        load_start = 1'b1;
        @(posedge clk);
        #2;
        load_start = 1'b0;
    endtask

    // full load of random words, optional idle gaps of 0..3 cycles
    task write_random_load(input bit gapped);
        logic [`WB_DW-1:0] d;
        int                gap;
        for (int i = 0; i < total; i++) begin
            d        = `WB_DW'($urandom);
            model[i] = d;
            if (gapped) begin
                gap = int'($urandom % 32'd4);
                idle_cycles(gap);
            end
            write_word(d);
        end
    endtask

    task run_sweep(input string name);
        int n;
        idle_cycles(2);
        @(posedge clk);
        #2;
        rd_start = 1'b1;
        @(posedge clk);  // edge that samples rd_start
        #2;
        rd_start      = 1'b0;
        sweep_lat     = 0;
        sweep_cnt     = 0;
        last_mask     = '0;
        sweep_timeout = 1'b0;
        while (!rd_valid && sweep_lat < timeout) begin
            @(posedge clk);
            #1;
            sweep_lat++;
        end
        if (!rd_valid) begin
            $display("%s: rd_valid did not rise within %0d cycles of rd_start", name, timeout);
            errors++;
            sweep_timeout = 1'b1;
        end else begin
            n = 0;
            while (rd_valid && n < 16) begin  // bounded, a stuck valid ends here
                sweep_vec[n] = weights;
                last_mask[n] = rd_last;
                n++;
                @(posedge clk);
                #1;
            end
            sweep_cnt = n;
        end
    endtask

    // kernel (oc, ic) is the (oc*TM + ic)-th block of K*K words in the stream
    function automatic wb_weights_t expected_tap(input int tap);
        wb_weights_t v;
        for (int oc = 0; oc < `WB_TN; oc++) begin
            for (int ic = 0; ic < `WB_TM; ic++) begin
                v.coef[oc][ic] = model[(oc * `WB_TM + ic) * taps + tap];
            end
        end
        return v;
    endfunction

    task check_sweep(input string name);
        if (!sweep_timeout) begin
            check_value({name, " valid count"}, vw'(taps), vw'(sweep_cnt));
            for (int t = 0; t < taps; t++) begin
                check_value($sformatf("%s tap %0d", name, t), expected_tap(t), sweep_vec[t]);
            end
        end
    endtask

    task finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    initial begin
        rst            = 1'b1;
        wr_ena         = 1'b0;
        wr_data        = '0;
        load_start     = 1'b0;
        rd_start       = 1'b0;
        errors         = 0;
        failed_tests   = 0;
        tests_run      = 0;
        test_err_start = 0;
        void'($urandom(32'ha60c_2d34));
        $readmemh("bench/weight_testdata.hex", file_words);

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (20) begin
            @(posedge clk);
            #1;
            check_value("reset_idle rd_valid", '0, vw'(rd_valid));
            check_value("reset_idle rd_last", '0, vw'(rd_last));
        end
        finish_test("reset_idle");

        if ($isunknown(file_words[total-1])) begin
            $display("file_load: test data file is missing or too short");
            errors++;
        end
        for (int i = 0; i < total; i++) begin
            model[i] = file_words[i];
            write_word(file_words[i]);  // back to back strobes
        end
        run_sweep("file_load");
        check_sweep("file_load");
        finish_test("file_load");

        run_sweep("framing");
        if (!sweep_timeout) begin
            check_value("framing latency", vw'(3), vw'(sweep_lat));
            check_value("framing last", vw'(16'(1) << (taps - 1)), vw'(last_mask));
        end
        check_sweep("framing");
        finish_test("framing");

        write_random_load(1'b1);  // counters wrapped after the file load
        run_sweep("gapped");
        check_sweep("gapped");
        finish_test("gapped");

        repeat (10) write_word(`WB_DW'($urandom));
        pulse_load_start();
        write_random_load(1'b0);
        run_sweep("restart");
        check_sweep("restart");
        finish_test("restart");

        run_sweep("repeat first");
        check_sweep("repeat first");
        for (int t = 0; t < taps; t++) begin
            first_vec[t] = sweep_vec[t];
        end
        idle_cycles(15);
        run_sweep("repeat second");
        check_sweep("repeat second");
        for (int t = 0; t < taps; t++) begin
            check_value($sformatf("repeat same tap %0d", t), first_vec[t], sweep_vec[t]);
        end
        finish_test("repeat");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/wbuf_pkg.sv
source/weight_write_router.sv
source/weight_bank.sv
source/weight_tap_sequencer.sv
source/weight_buffer.sv
bench/tb_weight_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the weight buffer testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_weight_buffer \
    -Mdir obj_dir -o sim_weight_buffer > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $build_log"
    exit 1
fi

./obj_dir/sim_weight_buffer > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$sim_log"; then
    exit 0
fi
echo "simulation reported failures, see $sim_log"
exit 1

// ==== bench/weight_testdata.hex ====
// one 16-bit coefficient per line, hex, in stream order
// order: output channel, then input channel, then kernel tap 0..8
// oc 0, ic 0
0012
ffe7
0105
fff9
0040
ff80
0003
7ffe
8001
// oc 0, ic 1
1a2b
3c4d
5e6f
0718
293a
4b5c
6d7e
8f90
a1b2
// oc 1, ic 0
c3d4
e5f6
0102
0304
0506
0708
090a
0b0c
0d0e
// oc 1, ic 1
fedc
ba98
7654
3210
0f1e
2d3c
4b5a
6978
8796
